// File: compile.f
verilog/cce_cfg_pkg.sv
verilog/cce_msg_pkg.sv
verilog/cce_dir.sv
verilog/cce_mem_port.sv
verilog/cce_ctrl.sv
verilog/cce_top.sv
sim/cce_tb.sv

// File: Makefile
# Verilator build and run for the CCE testbench

SRCS = $(shell cat compile.f)

obj_dir/Vcce_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module cce_tb -f compile.f

run: obj_dir/Vcce_tb sim/cce_patterns.txt
	obj_dir/Vcce_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: sim/cce_patterns.txt
# q src rtype addr : request, rtype 0 rd_shared / 1 rd_excl, then its commands in order
# c dst ctype addr : expected command, ctype 0 inv / 1 downgrade / 2 fill_s / 3 fill_m; x : reset
q 0 0 3
c 0 2 3
q 2 0 3
c 2 2 3
q 1 0 3
c 1 2 3
q 1 1 3
c 0 0 3
c 2 0 3
c 1 3 3
q 2 0 3
c 1 1 3
c 2 2 3
q 0 1 3
c 1 0 3
c 2 0 3
c 0 3 3
q 2 1 a
c 2 3 a
q 2 1 a
c 2 3 a
x
q 3 1 3
c 3 3 3
q 0 0 a
c 0 2 a

// File: sim/cce_tb.sv
// self-checking testbench for cce_top, replays sim/cce_patterns.txt against LCE and memory models
`timescale 1ns/10ps

module cce_tb;

  logic                   clk_i;
  logic                   rst_i;
  cce_msg_pkg::lce_req_s  lce_req_i;
  logic                   lce_req_v_i;
  logic                   lce_req_ready_o;
  cce_msg_pkg::lce_resp_s lce_resp_i;
  logic                   lce_resp_v_i;
  logic                   lce_resp_ready_o;
  cce_msg_pkg::lce_cmd_s  lce_cmd_o;
  logic                   lce_cmd_v_o;
  logic                   lce_cmd_ready_i;
  cce_msg_pkg::mem_fwd_s  mem_fwd_o;
  logic                   mem_fwd_v_o;
  logic                   mem_fwd_ready_i;
  cce_msg_pkg::mem_rev_s  mem_rev_i;
  logic                   mem_rev_v_i;
  logic                   mem_rev_ready_o;

  integer seed = 32'hfcd8;
  int     errors = 0;
  int     num_reqs = 0;
  int     reqs_run = 0;
  int     reqs_failed = 0;
  bit     loaded = 1'b0;
  bit     req_bad;
  bit     fill_seen;
  bit     cmd_hold;
  bit     fwd_hold;

  cce_msg_pkg::lce_cmd_s                  cmd_prev;
  cce_msg_pkg::mem_fwd_s                  fwd_prev;
  cce_msg_pkg::lce_cmd_s                  cmd_q[$];
  logic [cce_cfg_pkg::blk_addr_width-1:0] fwd_q[$];

  // parsed pattern lines
  byte op_key[$];
  int  op_a[$];
  int  op_b[$];
  int  op_c[$];

  cce_top dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lce_req_i        (lce_req_i),
    .lce_req_v_i      (lce_req_v_i),
    .lce_req_ready_o  (lce_req_ready_o),
    .lce_resp_i       (lce_resp_i),
    .lce_resp_v_i     (lce_resp_v_i),
    .lce_resp_ready_o (lce_resp_ready_o),
    .lce_cmd_o        (lce_cmd_o),
    .lce_cmd_v_o      (lce_cmd_v_o),
    .lce_cmd_ready_i  (lce_cmd_ready_i),
    .mem_fwd_o        (mem_fwd_o),
    .mem_fwd_v_o      (mem_fwd_v_o),
    .mem_fwd_ready_i  (mem_fwd_ready_i),
    .mem_rev_i        (mem_rev_i),
    .mem_rev_v_i      (mem_rev_v_i),
    .mem_rev_ready_o  (mem_rev_ready_o)
  );

  // memory word is the block address in every nibble
  function automatic logic [cce_cfg_pkg::data_width-1:0] fill_word(
    input logic [cce_cfg_pkg::blk_addr_width-1:0] addr
  );
    return {(cce_cfg_pkg::data_width / cce_cfg_pkg::blk_addr_width){addr}};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
      errors++;
      req_bad = 1'b1;
    end
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ready on about three cycles out of four
  initial begin : backpressure
    forever begin
      @(posedge clk_i);
      #1;
      lce_cmd_ready_i = ($random(seed) & 3) != 0;
      mem_fwd_ready_i = ($random(seed) & 3) != 0;
    end
  end

  // handshakes sampled at the falling edge, transfer happens on the next rising edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      cmd_hold = 1'b0;
      fwd_hold = 1'b0;
    end else begin
      if (cmd_hold) begin
        assert (lce_cmd_v_o && lce_cmd_o == cmd_prev) else begin
          $display("[FAIL] lce_cmd_o: held %h, now %h with lce_cmd_v_o %h",
                   cmd_prev, lce_cmd_o, lce_cmd_v_o);
          errors++;
          req_bad = 1'b1;
        end
      end
      if (fwd_hold) begin
        assert (mem_fwd_v_o && mem_fwd_o == fwd_prev) else begin
          $display("[FAIL] mem_fwd_o: held %h, now %h with mem_fwd_v_o %h",
                   fwd_prev, mem_fwd_o, mem_fwd_v_o);
          errors++;
          req_bad = 1'b1;
        end
      end
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        cmd_q.push_back(lce_cmd_o);
        if (lce_cmd_o.ctype == cce_msg_pkg::e_cmd_fill_s ||
            lce_cmd_o.ctype == cce_msg_pkg::e_cmd_fill_m) begin
          fill_seen = 1'b1;
        end
      end
      if (mem_fwd_v_o && mem_fwd_ready_i) begin
        fwd_q.push_back(mem_fwd_o.addr);
      end
      cmd_hold = lce_cmd_v_o && !lce_cmd_ready_i;
      cmd_prev = lce_cmd_o;
      fwd_hold = mem_fwd_v_o && !mem_fwd_ready_i;
      fwd_prev = mem_fwd_o;
    end
  end

  // LCEs ack each inv or downgrade after 0 to 3 cycles
  initial begin : lce_model
    cce_msg_pkg::lce_resp_s ack;
    int delay;
    forever begin
      @(negedge clk_i);
      if (!rst_i && lce_cmd_v_o && lce_cmd_ready_i &&
          (lce_cmd_o.ctype == cce_msg_pkg::e_cmd_inv ||
           lce_cmd_o.ctype == cce_msg_pkg::e_cmd_downgrade)) begin
        ack.src  = lce_cmd_o.dst;
        ack.addr = lce_cmd_o.addr;
        delay    = {$random(seed)} % 4;
        @(posedge clk_i);
        repeat (delay) @(posedge clk_i);
        #1;
        lce_resp_i   = ack;
        lce_resp_v_i = 1'b1;
        do @(negedge clk_i); while (!lce_resp_ready_o);
        @(posedge clk_i);
        #1;
        lce_resp_v_i = 1'b0;
      end
    end
  end

  // memory answers 1 to 4 cycles after taking the request
  initial begin : mem_model
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
    int delay;
    forever begin
      @(negedge clk_i);
      if (!rst_i && mem_fwd_v_o && mem_fwd_ready_i) begin
        addr  = mem_fwd_o.addr;
        delay = {$random(seed)} % 4;
        @(posedge clk_i);
        repeat (delay) @(posedge clk_i);
        #1;
        mem_rev_i.addr = addr;
        mem_rev_i.data = fill_word(addr);
        mem_rev_v_i    = 1'b1;
        do @(negedge clk_i); while (!mem_rev_ready_o);
        @(posedge clk_i);
        #1;
        mem_rev_v_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (num_reqs * 200 + 100) @(posedge clk_i);
    $display("timeout: the run did not end within %0d cycles", num_reqs * 200 + 100);
    $display("CHECKS FAILED");
    $finish;
  end

  // caller raises nothing, reset starts here and lasts 3 cycles
  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("lce_req_ready_o", 1, 32'(lce_req_ready_o));
    check_value("lce_cmd_v_o", 0, 32'(lce_cmd_v_o));
    check_value("mem_fwd_v_o", 0, 32'(mem_fwd_v_o));
    check_value("lce_resp_ready_o", 0, 32'(lce_resp_ready_o));
    check_value("mem_rev_ready_o", 0, 32'(mem_rev_ready_o));
  endtask

  // expected commands are pattern entries first .. first+count-1
  task automatic run_request(input int src, input int rtype, input int addr,
                             input int first, input int count);
    cce_msg_pkg::lce_cmd_s got;
    logic [31:0] exp_data;
    int cycles;
    req_bad   = 1'b0;
    fill_seen = 1'b0;
    cmd_q.delete();
    fwd_q.delete();
    @(posedge clk_i);
    #1;
    lce_req_i.src   = 2'(src);
    lce_req_i.rtype = cce_msg_pkg::req_type_e'(rtype);
    lce_req_i.addr  = 4'(addr);
    lce_req_v_i     = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!lce_req_ready_o && cycles < 200);
    assert (lce_req_ready_o) else begin
      $display("request was not accepted within 200 cycles");
      errors++;
      req_bad = 1'b1;
    end
    @(posedge clk_i);
    #1;
    lce_req_v_i = 1'b0;
    cycles = 0;
    while (!fill_seen && cycles < 200) begin
      @(posedge clk_i);
      cycles++;
    end
    assert (fill_seen) else begin
      $display("no fill arrived within 200 cycles of the request");
      errors++;
      req_bad = 1'b1;
    end
    check_value("lce_cmd count", count, cmd_q.size());
    for (int i = 0; i < count && i < cmd_q.size(); i++) begin
      got      = cmd_q[i];
      exp_data = (op_b[first + i] >= 2) ? fill_word(4'(addr)) : 32'd0;
      check_value("lce_cmd_o.dst", op_a[first + i], 32'(got.dst));
      check_value("lce_cmd_o.ctype", op_b[first + i], 32'(got.ctype));
      check_value("lce_cmd_o.addr", op_c[first + i], 32'(got.addr));
      check_value("lce_cmd_o.data", exp_data, got.data);
    end
    check_value("mem_fwd count", 1, fwd_q.size());
    if (fwd_q.size() > 0) begin
      check_value("mem_fwd_o.addr", addr, 32'(fwd_q[0]));
    end
    reqs_run++;
    if (req_bad) begin
      reqs_failed++;
    end
    $display("request %0d: lce %0d %s block %h, %0d commands, %s", reqs_run, src,
             (rtype != 0) ? "rd_excl" : "rd_shared", addr, count, req_bad ? "fail" : "ok");
  endtask

  initial begin : main
    string line;
    int fd;
    int n;
    int a;
    int b;
    int c;
    int idx;
    int count;
    rst_i           = 1'b1;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    lce_resp_i      = '0;
    lce_resp_v_i    = 1'b0;
    lce_cmd_ready_i = 1'b0;
    mem_fwd_ready_i = 1'b0;
    mem_rev_i       = '0;
    mem_rev_v_i     = 1'b0;
    fd = $fopen("sim/cce_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/cce_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && (line[0] == "q" || line[0] == "c" || line[0] == "x")) begin
          a = 0;
          b = 0;
          c = 0;
          if (line[0] != "x") begin
            n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c);
          end
          op_key.push_back(line[0]);
          op_a.push_back(a);
          op_b.push_back(b);
          op_c.push_back(c);
          if (line[0] == "q") begin
            num_reqs++;
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    apply_reset();
    idx = 0;
    while (idx < op_key.size()) begin
      if (op_key[idx] == "x") begin
        @(posedge clk_i);
        #1;
        apply_reset();
        idx++;
      end else if (op_key[idx] == "q") begin
        count = 0;
        while (idx + 1 + count < op_key.size() && op_key[idx + 1 + count] == "c") begin
          count++;
        end
        run_request(op_a[idx], op_b[idx], op_c[idx], idx + 1, count);
        idx += 1 + count;
      end else begin
        $display("pattern entry %0d is a command with no request before it", idx);
        errors++;
        idx++;
      end
    end
    $display("%0d requests, %0d passed, %0d failed, %0d check errors",
             reqs_run, reqs_run - reqs_failed, reqs_failed, errors);
    if (errors == 0 && reqs_failed == 0 && num_reqs > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/cce_top.sv
// CCE top level, joins directory, memory port and transaction controller
`timescale 1ns/10ps

module cce_top (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // LCE side
  input  cce_msg_pkg::lce_req_s  lce_req_i,
  input  logic                   lce_req_v_i,
  output logic                   lce_req_ready_o,

  input  cce_msg_pkg::lce_resp_s lce_resp_i,
  input  logic                   lce_resp_v_i,
  output logic                   lce_resp_ready_o,

  output cce_msg_pkg::lce_cmd_s  lce_cmd_o,
  output logic                   lce_cmd_v_o,
  input  logic                   lce_cmd_ready_i,

  // memory side
  output cce_msg_pkg::mem_fwd_s  mem_fwd_o,
  output logic                   mem_fwd_v_o,
  input  logic                   mem_fwd_ready_i,

  input  cce_msg_pkg::mem_rev_s  mem_rev_i,
  input  logic                   mem_rev_v_i,
  output logic                   mem_rev_ready_o
);

  logic                                   dir_rd_en;
  logic [cce_cfg_pkg::blk_addr_width-1:0] dir_rd_addr;
  cce_msg_pkg::dir_entry_s                dir_rd_entry;
  logic                                   dir_wr_en;
  logic [cce_cfg_pkg::blk_addr_width-1:0] dir_wr_addr;
  cce_msg_pkg::dir_entry_s                dir_wr_entry;

  logic                                   fetch;
  logic [cce_cfg_pkg::blk_addr_width-1:0] fetch_addr;
  logic                                   fetch_done;
  logic [cce_cfg_pkg::data_width-1:0]     fetch_data;

  cce_dir dir (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_en_i    (dir_rd_en),
    .rd_addr_i  (dir_rd_addr),
    .rd_entry_o (dir_rd_entry),
    .wr_en_i    (dir_wr_en),
    .wr_addr_i  (dir_wr_addr),
    .wr_entry_i (dir_wr_entry)
  );

  cce_mem_port mem_port (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_i         (fetch),
    .fetch_addr_i    (fetch_addr),
    .done_o          (fetch_done),
    .data_o          (fetch_data),
    .mem_fwd_o       (mem_fwd_o),
    .mem_fwd_v_o     (mem_fwd_v_o),
    .mem_fwd_ready_i (mem_fwd_ready_i),
    .mem_rev_i       (mem_rev_i),
    .mem_rev_v_i     (mem_rev_v_i),
    .mem_rev_ready_o (mem_rev_ready_o)
  );

  cce_ctrl ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lce_req_i        (lce_req_i),
    .lce_req_v_i      (lce_req_v_i),
    .lce_req_ready_o  (lce_req_ready_o),
    .lce_resp_i       (lce_resp_i),
    .lce_resp_v_i     (lce_resp_v_i),
    .lce_resp_ready_o (lce_resp_ready_o),
    .lce_cmd_o        (lce_cmd_o),
    .lce_cmd_v_o      (lce_cmd_v_o),
    .lce_cmd_ready_i  (lce_cmd_ready_i),
    .dir_rd_en_o      (dir_rd_en),
    .dir_rd_addr_o    (dir_rd_addr),
    .dir_rd_entry_i   (dir_rd_entry),
    .dir_wr_en_o      (dir_wr_en),
    .dir_wr_addr_o    (dir_wr_addr),
    .dir_wr_entry_o   (dir_wr_entry),
    .fetch_o          (fetch),
    .fetch_addr_o     (fetch_addr),
    .fetch_done_i     (fetch_done),
    .fetch_data_i     (fetch_data)
  );

endmodule

// File: verilog/cce_ctrl.sv
// transaction controller that runs one MSI request through inv/downgrade, fetch and fill
`timescale 1ns/10ps

module cce_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  cce_msg_pkg::lce_req_s                  lce_req_i,
  input  logic                                   lce_req_v_i,
  output logic                                   lce_req_ready_o,

  input  cce_msg_pkg::lce_resp_s                 lce_resp_i,
  input  logic                                   lce_resp_v_i,
  output logic                                   lce_resp_ready_o,

  output cce_msg_pkg::lce_cmd_s                  lce_cmd_o,
  output logic                                   lce_cmd_v_o,
  input  logic                                   lce_cmd_ready_i,

  output logic                                   dir_rd_en_o,
  output logic [cce_cfg_pkg::blk_addr_width-1:0] dir_rd_addr_o,
  input  cce_msg_pkg::dir_entry_s                dir_rd_entry_i,

  output logic                                   dir_wr_en_o,
  output logic [cce_cfg_pkg::blk_addr_width-1:0] dir_wr_addr_o,
  output cce_msg_pkg::dir_entry_s                dir_wr_entry_o,

  output logic                                   fetch_o,
  output logic [cce_cfg_pkg::blk_addr_width-1:0] fetch_addr_o,
  input  logic                                   fetch_done_i,
  input  logic [cce_cfg_pkg::data_width-1:0]     fetch_data_i
);

  typedef enum logic [2:0] {
    e_idle,
    e_lookup,
    e_send_inv,
    e_wait_ack,
    e_fetch,
    e_send_fill
  } state_e;

  state_e                             state_r;
  cce_msg_pkg::lce_req_s              req_r;
  cce_msg_pkg::dir_entry_s            entry_r;
  logic [cce_cfg_pkg::num_lce-1:0]    pending_r;
  logic [cce_cfg_pkg::num_lce-1:0]    lookup_pending;
  logic [cce_cfg_pkg::num_lce-1:0]    pending_left;
  logic [cce_cfg_pkg::data_width-1:0] data_r;
  logic                               fetch_issued_r;
  logic                               is_shared;
  logic                               downgrade;

  function automatic logic [cce_cfg_pkg::num_lce-1:0] id_mask(
    input logic [cce_cfg_pkg::lce_id_width-1:0] id
  );
    return {{(cce_cfg_pkg::num_lce-1){1'b0}}, 1'b1} << id;
  endfunction

  // scan from the top so the lowest set bit wins
  function automatic logic [cce_cfg_pkg::lce_id_width-1:0] lowest_id(
    input logic [cce_cfg_pkg::num_lce-1:0] vec
  );
    logic [cce_cfg_pkg::lce_id_width-1:0] id;
    id = '0;
    for (int i = cce_cfg_pkg::num_lce - 1; i >= 0; i--) begin
      if (vec[i]) id = i[cce_cfg_pkg::lce_id_width-1:0];
    end
    return id;
  endfunction

  assign is_shared = (req_r.rtype == cce_msg_pkg::e_req_rd_shared);

  // holders to invalidate or downgrade according to the fresh entry
  always_comb begin
    lookup_pending = '0;
    if (is_shared) begin
      if (dir_rd_entry_i.state == cce_msg_pkg::e_dir_m && dir_rd_entry_i.owner != req_r.src)
        lookup_pending = id_mask(dir_rd_entry_i.owner);
    end else if (dir_rd_entry_i.state == cce_msg_pkg::e_dir_s) begin
      lookup_pending = dir_rd_entry_i.sharers & ~id_mask(req_r.src);
    end else if (dir_rd_entry_i.state == cce_msg_pkg::e_dir_m) begin
      lookup_pending = id_mask(dir_rd_entry_i.owner) & ~id_mask(req_r.src);
    end
  end

  assign pending_left = pending_r & ~id_mask(lce_resp_i.src);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r        <= e_idle;
      pending_r      <= '0;
      fetch_issued_r <= 1'b0;
    end else begin
      case (state_r)
        e_idle: if (lce_req_v_i) state_r <= e_lookup;
        e_lookup: begin
          pending_r <= lookup_pending;
          state_r   <= (lookup_pending != '0) ? e_send_inv : e_fetch;
        end
        e_send_inv: if (lce_cmd_ready_i) state_r <= e_wait_ack;
        e_wait_ack: begin
          if (lce_resp_v_i) begin
            pending_r <= pending_left;
            state_r   <= (pending_left != '0) ? e_send_inv : e_fetch;
          end
        end
        e_fetch: begin
          fetch_issued_r <= 1'b1;
          if (fetch_done_i) begin
            fetch_issued_r <= 1'b0;
            state_r        <= e_send_fill;
          end
        end
        e_send_fill: if (lce_cmd_ready_i) state_r <= e_idle;
        default: state_r <= e_idle;
      endcase
    end
  end

  // capture request, looked-up entry and fill word
  always_ff @(posedge clk_i) begin
    if (state_r == e_idle && lce_req_v_i) req_r <= lce_req_i;
    if (state_r == e_lookup) entry_r <= dir_rd_entry_i;
    if (state_r == e_fetch && fetch_done_i) data_r <= fetch_data_i;
  end

  assign lce_req_ready_o  = (state_r == e_idle);
  assign lce_resp_ready_o = (state_r == e_wait_ack);
  assign dir_rd_en_o      = (state_r == e_idle) && lce_req_v_i;
  assign dir_rd_addr_o    = lce_req_i.addr;
  assign fetch_o          = (state_r == e_fetch) && !fetch_issued_r;
  assign fetch_addr_o     = req_r.addr;

  // inv and downgrade carry no data
  always_comb begin
    lce_cmd_v_o    = (state_r == e_send_inv) || (state_r == e_send_fill);
    lce_cmd_o.addr = req_r.addr;
    if (state_r == e_send_fill) begin
      lce_cmd_o.dst   = req_r.src;
      lce_cmd_o.ctype = is_shared ? cce_msg_pkg::e_cmd_fill_s : cce_msg_pkg::e_cmd_fill_m;
      lce_cmd_o.data  = data_r;
    end else begin
      lce_cmd_o.dst   = lowest_id(pending_r);
      lce_cmd_o.ctype = is_shared ? cce_msg_pkg::e_cmd_downgrade : cce_msg_pkg::e_cmd_inv;
      lce_cmd_o.data  = '0;
    end
  end

  // old owner joins the sharers after a downgrade
  assign downgrade = is_shared && (entry_r.state == cce_msg_pkg::e_dir_m)
                     && (entry_r.owner != req_r.src);

  assign dir_wr_en_o   = (state_r == e_send_fill) && lce_cmd_ready_i;
  assign dir_wr_addr_o = req_r.addr;

  always_comb begin
    dir_wr_entry_o.owner = req_r.src;
    if (is_shared) begin
      dir_wr_entry_o.state   = cce_msg_pkg::e_dir_s;
      dir_wr_entry_o.sharers = entry_r.sharers | id_mask(req_r.src)
                               | (downgrade ? id_mask(entry_r.owner) : '0);
    end else begin
      dir_wr_entry_o.state   = cce_msg_pkg::e_dir_m;
      dir_wr_entry_o.sharers = id_mask(req_r.src);
    end
  end

endmodule

// File: verilog/cce_mem_port.sv
// memory side of the CCE that sends one block read and returns the data word to the controller
`timescale 1ns/10ps

module cce_mem_port (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  logic                                   fetch_i,
  input  logic [cce_cfg_pkg::blk_addr_width-1:0] fetch_addr_i,
  output logic                                   done_o,
  output logic [cce_cfg_pkg::data_width-1:0]     data_o,

  output cce_msg_pkg::mem_fwd_s                  mem_fwd_o,
  output logic                                   mem_fwd_v_o,
  input  logic                                   mem_fwd_ready_i,

  input  cce_msg_pkg::mem_rev_s                  mem_rev_i,
  input  logic                                   mem_rev_v_i,
  output logic                                   mem_rev_ready_o
);

  typedef enum logic [1:0] {
    e_mp_idle,
    e_mp_send,
    e_mp_wait
  } mp_state_e;

  mp_state_e                              state_r;
  logic [cce_cfg_pkg::blk_addr_width-1:0] addr_r;
  logic [cce_cfg_pkg::data_width-1:0]     data_r;
  logic                                   done_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_mp_idle;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        e_mp_idle: if (fetch_i) state_r <= e_mp_send;
        // hold the request until memory takes it
        e_mp_send: if (mem_fwd_ready_i) state_r <= e_mp_wait;
        e_mp_wait: begin
          if (mem_rev_v_i) begin
            state_r <= e_mp_idle;
            done_r  <= 1'b1;
          end
        end
        default: state_r <= e_mp_idle;
      endcase
    end
  end

  // latch the block address and the returned word
  always_ff @(posedge clk_i) begin
    if (state_r == e_mp_idle && fetch_i) begin
      addr_r <= fetch_addr_i;
    end
    if (state_r == e_mp_wait && mem_rev_v_i) begin
      data_r <= mem_rev_i.data;
    end
  end

  assign mem_fwd_v_o     = (state_r == e_mp_send);
  assign mem_fwd_o.addr  = addr_r;
  assign mem_rev_ready_o = (state_r == e_mp_wait);
  assign done_o          = done_r;
  assign data_o          = data_r;

endmodule

// File: verilog/cce_dir.sv
// directory storage with one MSI entry per block, registered read and one write port
`timescale 1ns/10ps

module cce_dir (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  // read port, entry valid the cycle after rd_en_i
  input  logic                                   rd_en_i,
  input  logic [cce_cfg_pkg::blk_addr_width-1:0] rd_addr_i,
  output cce_msg_pkg::dir_entry_s                rd_entry_o,

  // write port, takes effect at the clock edge
  input  logic                                   wr_en_i,
  input  logic [cce_cfg_pkg::blk_addr_width-1:0] wr_addr_i,
  input  cce_msg_pkg::dir_entry_s                wr_entry_i
);

  cce_msg_pkg::dir_entry_s dir_r [cce_cfg_pkg::num_blocks];
  cce_msg_pkg::dir_entry_s rd_entry_r;

  // every block starts invalid with no sharers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < cce_cfg_pkg::num_blocks; i++) begin
        dir_r[i].state   <= cce_msg_pkg::e_dir_i;
        dir_r[i].sharers <= '0;
        dir_r[i].owner   <= '0;
      end
    end else if (wr_en_i) begin
      dir_r[wr_addr_i] <= wr_entry_i;
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_entry_r <= dir_r[rd_addr_i];
    end
  end

  assign rd_entry_o = rd_entry_r;

endmodule

// File: verilog/cce_msg_pkg.sv
// message encodings and packed channel structs exchanged between LCEs, CCE and memory
package cce_msg_pkg;

  // LCE request kinds
  typedef enum logic {
    e_req_rd_shared,
    e_req_rd_excl
  } req_type_e;

  // commands sent from the CCE to an LCE
  typedef enum logic [1:0] {
    e_cmd_inv,
    e_cmd_downgrade,
    e_cmd_fill_s,
    e_cmd_fill_m
  } cmd_type_e;

  // MSI state held per block in the directory
  typedef enum logic [1:0] {
    e_dir_i,
    e_dir_s,
    e_dir_m
  } dir_state_e;

  typedef struct packed {
    logic [cce_cfg_pkg::lce_id_width-1:0]   src;
    req_type_e                              rtype;
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
  } lce_req_s;

  // ack for an inv or downgrade
  typedef struct packed {
    logic [cce_cfg_pkg::lce_id_width-1:0]   src;
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
  } lce_resp_s;

  // data is zero unless the command is a fill
  typedef struct packed {
    logic [cce_cfg_pkg::lce_id_width-1:0]   dst;
    cmd_type_e                              ctype;
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
    logic [cce_cfg_pkg::data_width-1:0]     data;
  } lce_cmd_s;

  typedef struct packed {
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
  } mem_fwd_s;

  typedef struct packed {
    logic [cce_cfg_pkg::blk_addr_width-1:0] addr;
    logic [cce_cfg_pkg::data_width-1:0]     data;
  } mem_rev_s;

  // sharers is a bit per LCE, owner only meaningful in M
  typedef struct packed {
    dir_state_e                           state;
    logic [cce_cfg_pkg::num_lce-1:0]      sharers;
    logic [cce_cfg_pkg::lce_id_width-1:0] owner;
  } dir_entry_s;

endpackage

// File: verilog/cce_cfg_pkg.sv
// system sizes for the coherence engine, referenced by scoped name from RTL and testbench
package cce_cfg_pkg;

  // local cache engines served by the directory
  localparam int num_lce = 4;

  // LCE id width, enough to index num_lce engines
  localparam int lce_id_width = 2;

  // block index width, one directory entry per block
  localparam int blk_addr_width = 4;

  // number of tracked blocks
  localparam int num_blocks = 1 << blk_addr_width;

  // a block carries a single data word
  localparam int data_width = 32;

endpackage
